//--- logic/boardcfg_pkg.sv
package boardcfg_pkg;

	// measured board clocks, one edge counter each
	localparam int n_fcnt = 16;
	localparam int fcnt_sel_width = $clog2(n_fcnt);
	localparam int cnt_width = 32;

	// gate window in hw cycles
	localparam int window_cycles = 256;
	localparam int gate_width = $clog2(window_cycles);
	localparam logic [gate_width-1:0] gate_last = gate_width'(window_cycles - 1);

	// reset stretch length and its down-counter
	localparam int reset_stretch = 4;
	localparam int stretch_width = $clog2(reset_stretch + 1);
	localparam logic [stretch_width-1:0] stretch_load = stretch_width'(reset_stretch);

	// bus and field sizes
	localparam int reg_width = 32;
	localparam int addr_width = 6;
	localparam int led_width = 8;
	localparam int nshot_width = 16;
	localparam int heart_width = 24;

	// register map
	localparam logic [addr_width-1:0] addr_led = 6'h00;
	localparam logic [addr_width-1:0] addr_cmd = 6'h01;
	localparam logic [addr_width-1:0] addr_decim = 6'h02;
	localparam logic [addr_width-1:0] addr_rev = 6'h03;
	localparam logic [addr_width-1:0] addr_status = 6'h04;
	// sixteen frequency slots from here on
	localparam logic [addr_width-1:0] addr_freq_base = 6'h10;

	localparam logic [reg_width-1:0] revision_word = 32'h0b0c_0103;

	// write word as seen at addr_led
	typedef struct packed {
		logic [15:0] reserved;
		logic [led_width-1:0] test1;
		logic [led_width-1:0] test;
	} led_view_t;

	// write word as seen at addr_cmd
	typedef struct packed {
		logic [nshot_width-1:0] nshot;
		logic [12:0] reserved;
		logic resetacc;
		logic stb_dspreset;
		logic stb_start;
	} cmd_view_t;

	typedef union packed {
		led_view_t led_view;
		cmd_view_t cmd_view;
	} cfg_word_u;

endpackage

//--- logic/boardcfg_top.sv
`timescale 1ns/1ps

module boardcfg_top (
	input  logic hw,
	input  logic rst,
	input  logic [boardcfg_pkg::n_fcnt-1:0] fin,
	input  logic wr_stb,
	input  logic [boardcfg_pkg::addr_width-1:0] wr_addr,
	input  logic [boardcfg_pkg::reg_width-1:0] wr_data,
	input  logic [boardcfg_pkg::addr_width-1:0] rd_addr,
	output logic [boardcfg_pkg::reg_width-1:0] rd_data,
	output logic [boardcfg_pkg::led_width-1:0] led_heart,
	output logic [boardcfg_pkg::led_width-1:0] led_test,
	output logic [boardcfg_pkg::led_width-1:0] led_test1,
	output logic dsp_start,
	output logic dsp_reset,
	output logic dsp_resetacc,
	output logic [boardcfg_pkg::nshot_width-1:0] dsp_nshot,
	output logic [boardcfg_pkg::reg_width-1:0] dsp_decimator,
	output logic cfg_reset
);

	// counter bank to readout
	logic [boardcfg_pkg::n_fcnt*boardcfg_pkg::cnt_width-1:0] freq_counts;
	logic freq_valid;

	// register file to readout
	logic [boardcfg_pkg::led_width-1:0] reg_test;
	logic [boardcfg_pkg::led_width-1:0] reg_test1;

	freq_counter_bank u_fcnt (
		.hw          (hw),
		.rst         (rst),
		.fin         (fin),
		.freq_counts (freq_counts),
		.freq_valid  (freq_valid)
	);

	// nshot and decimator nets also go straight out to the DSP
	cfg_register_file u_regs (
		.hw            (hw),
		.rst           (rst),
		.wr_stb        (wr_stb),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.reg_test      (reg_test),
		.reg_test1     (reg_test1),
		.reg_nshot     (dsp_nshot),
		.reg_decimator (dsp_decimator),
		.dsp_start     (dsp_start),
		.dsp_reset     (dsp_reset),
		.dsp_resetacc  (dsp_resetacc),
		.cfg_reset     (cfg_reset)
	);

	status_readout u_status (
		.hw            (hw),
		.rst           (rst),
		.rd_addr       (rd_addr),
		.freq_counts   (freq_counts),
		.freq_valid    (freq_valid),
		.reg_test      (reg_test),
		.reg_test1     (reg_test1),
		.reg_nshot     (dsp_nshot),
		.reg_decimator (dsp_decimator),
		.rd_data       (rd_data),
		.led_heart     (led_heart),
		.led_test      (led_test),
		.led_test1     (led_test1)
	);

endmodule

//--- logic/cfg_register_file.sv
`timescale 1ns/1ps

module cfg_register_file (
	input  logic hw,
	input  logic rst,
	input  logic wr_stb,
	input  logic [boardcfg_pkg::addr_width-1:0] wr_addr,
	input  logic [boardcfg_pkg::reg_width-1:0] wr_data,
	output logic [boardcfg_pkg::led_width-1:0] reg_test,
	output logic [boardcfg_pkg::led_width-1:0] reg_test1,
	output logic [boardcfg_pkg::nshot_width-1:0] reg_nshot,
	output logic [boardcfg_pkg::reg_width-1:0] reg_decimator,
	output logic dsp_start,
	output logic dsp_reset,
	output logic dsp_resetacc,
	output logic cfg_reset
);

	// same write word, decoded per address
	boardcfg_pkg::cfg_word_u wr_word;

	// decoded write enables
	logic wr_led;
	logic wr_cmd;
	logic wr_decim;

	// reset stretch counters
	logic [boardcfg_pkg::stretch_width-1:0] cfg_cnt;
	logic [boardcfg_pkg::stretch_width-1:0] dsp_cnt;
	logic soft_reset;

	assign wr_word = wr_data;

	assign wr_led = wr_stb && (wr_addr == boardcfg_pkg::addr_led);
	assign wr_cmd = wr_stb && (wr_addr == boardcfg_pkg::addr_cmd);
	assign wr_decim = wr_stb && (wr_addr == boardcfg_pkg::addr_decim);

	// soft DSP reset request from the command word
	assign soft_reset = wr_cmd && wr_word.cmd_view.stb_dspreset;

	// resets are high while their counters run
	assign cfg_reset = (cfg_cnt != '0);
	assign dsp_reset = (dsp_cnt != '0);

	// LED test bytes
	always_ff @(posedge hw) begin
		if (rst) begin
			reg_test <= '0;
			reg_test1 <= '0;
		end else if (wr_led) begin
			reg_test <= wr_word.led_view.test;
			reg_test1 <= wr_word.led_view.test1;
		end
	end

	// command fields, nshot and resetacc are kept as levels
	always_ff @(posedge hw) begin
		if (rst) begin
			reg_nshot <= '0;
			dsp_resetacc <= 1'b0;
		end else if (wr_cmd) begin
			reg_nshot <= wr_word.cmd_view.nshot;
			dsp_resetacc <= wr_word.cmd_view.resetacc;
		end
	end

	// start strobe, high only for the cycle after the write
	always_ff @(posedge hw) begin
		if (rst) begin
			dsp_start <= 1'b0;
		end else begin
			dsp_start <= wr_cmd && wr_word.cmd_view.stb_start;
		end
	end

	// decimator takes the full word
	always_ff @(posedge hw) begin
		if (rst) begin
			reg_decimator <= '0;
		end else if (wr_decim) begin
			reg_decimator <= wr_data;
		end
	end

	// config reset only follows rst
	always_ff @(posedge hw) begin
		if (rst) begin
			cfg_cnt <= boardcfg_pkg::stretch_load;
		end else if (cfg_cnt != '0) begin
			cfg_cnt <= cfg_cnt - 1'b1;
		end
	end

	// dsp reset follows rst and the soft reset command
	always_ff @(posedge hw) begin
		if (rst || soft_reset) begin
			dsp_cnt <= boardcfg_pkg::stretch_load;
		end else if (dsp_cnt != '0) begin
			dsp_cnt <= dsp_cnt - 1'b1;
		end
	end

endmodule

//--- logic/freq_counter_bank.sv
`timescale 1ns/1ps

module freq_counter_bank (
	input  logic hw,
	input  logic rst,
	input  logic [boardcfg_pkg::n_fcnt-1:0] fin,
	output logic [boardcfg_pkg::n_fcnt*boardcfg_pkg::cnt_width-1:0] freq_counts,
	output logic freq_valid
);

	// two-flop synchronizer plus edge history
	logic [boardcfg_pkg::n_fcnt-1:0] fin_meta;
	logic [boardcfg_pkg::n_fcnt-1:0] fin_sync;
	logic [boardcfg_pkg::n_fcnt-1:0] fin_prev;
	logic [boardcfg_pkg::n_fcnt-1:0] fin_rise;

	// shared gate counter
	logic [boardcfg_pkg::gate_width-1:0] gate_cnt;
	logic window_end;

	// running counts and the counts of the last full window
	logic [boardcfg_pkg::n_fcnt-1:0][boardcfg_pkg::cnt_width-1:0] edge_cnt;
	logic [boardcfg_pkg::n_fcnt-1:0][boardcfg_pkg::cnt_width-1:0] latched;

	// one-cycle pulse per rising edge of the synced input
	assign fin_rise = fin_sync & ~fin_prev;
	assign window_end = (gate_cnt == boardcfg_pkg::gate_last);
	assign freq_counts = latched;

	always_ff @(posedge hw) begin
		if (rst) begin
			fin_meta <= '0;
			fin_sync <= '0;
			fin_prev <= '0;
		end else begin
			fin_meta <= fin;
			fin_sync <= fin_meta;
			fin_prev <= fin_sync;
		end
	end

	// window runs 0 .. window_cycles-1 then wraps
	always_ff @(posedge hw) begin
		if (rst) begin
			gate_cnt <= '0;
			freq_valid <= 1'b0;
		end else begin
			if (window_end) begin
				gate_cnt <= '0;
			end else begin
				gate_cnt <= gate_cnt + 1'b1;
			end
			// sticky once the first window has closed
			freq_valid <= freq_valid | window_end;
		end
	end

	// all inputs latch on the same edge, so they share one window
	always_ff @(posedge hw) begin
		if (rst) begin
			edge_cnt <= '0;
			latched <= '0;
		end else begin
			for (int i = 0; i < boardcfg_pkg::n_fcnt; i++) begin
				if (window_end) begin
					// the edge on the last cycle still belongs to this window
					latched[i] <= edge_cnt[i]
						+ {{(boardcfg_pkg::cnt_width-1){1'b0}}, fin_rise[i]};
					edge_cnt[i] <= '0;
				end else begin
					edge_cnt[i] <= edge_cnt[i]
						+ {{(boardcfg_pkg::cnt_width-1){1'b0}}, fin_rise[i]};
				end
			end
		end
	end

endmodule

//--- logic/status_readout.sv
`timescale 1ns/1ps

module status_readout (
	input  logic hw,
	input  logic rst,
	input  logic [boardcfg_pkg::addr_width-1:0] rd_addr,
	input  logic [boardcfg_pkg::n_fcnt*boardcfg_pkg::cnt_width-1:0] freq_counts,
	input  logic freq_valid,
	input  logic [boardcfg_pkg::led_width-1:0] reg_test,
	input  logic [boardcfg_pkg::led_width-1:0] reg_test1,
	input  logic [boardcfg_pkg::nshot_width-1:0] reg_nshot,
	input  logic [boardcfg_pkg::reg_width-1:0] reg_decimator,
	output logic [boardcfg_pkg::reg_width-1:0] rd_data,
	output logic [boardcfg_pkg::led_width-1:0] led_heart,
	output logic [boardcfg_pkg::led_width-1:0] led_test,
	output logic [boardcfg_pkg::led_width-1:0] led_test1
);

	// counts split back into slots
	logic [boardcfg_pkg::n_fcnt-1:0][boardcfg_pkg::cnt_width-1:0] freq_slots;
	logic [boardcfg_pkg::addr_width-1:0] slot_off;
	logic slot_hit;

	// readback words laid out like the write views
	boardcfg_pkg::cfg_word_u led_word;
	boardcfg_pkg::cfg_word_u cmd_word;

	logic [boardcfg_pkg::reg_width-1:0] rd_next;
	logic [boardcfg_pkg::heart_width-1:0] heart_cnt;

	assign freq_slots = freq_counts;

	// addresses below the base wrap to a large offset
	assign slot_off = rd_addr - boardcfg_pkg::addr_freq_base;
	assign slot_hit = (slot_off < boardcfg_pkg::n_fcnt);

	always_comb begin
		led_word = '0;
		led_word.led_view.test = reg_test;
		led_word.led_view.test1 = reg_test1;
		// strobes read back as zero
		cmd_word = '0;
		cmd_word.cmd_view.nshot = reg_nshot;
	end

	// read mux, unmapped reads zero
	always_comb begin
		rd_next = '0;
		if (slot_hit) begin
			rd_next = freq_slots[slot_off[boardcfg_pkg::fcnt_sel_width-1:0]];
		end else begin
			case (rd_addr)
				boardcfg_pkg::addr_led: rd_next = led_word;
				boardcfg_pkg::addr_cmd: rd_next = cmd_word;
				boardcfg_pkg::addr_decim: rd_next = reg_decimator;
				boardcfg_pkg::addr_rev: rd_next = boardcfg_pkg::revision_word;
				// shot count on top, done flag in bit 0
				boardcfg_pkg::addr_status: rd_next = {reg_nshot,
					{(boardcfg_pkg::reg_width-boardcfg_pkg::nshot_width-1){1'b0}},
					freq_valid};
				default: rd_next = '0;
			endcase
		end
	end

	// one cycle read latency
	always_ff @(posedge hw) begin
		if (rst) begin
			rd_data <= '0;
		end else begin
			rd_data <= rd_next;
		end
	end

	// free-running heartbeat
	always_ff @(posedge hw) begin
		if (rst) begin
			heart_cnt <= '0;
		end else begin
			heart_cnt <= heart_cnt + 1'b1;
		end
	end

	// top byte of the heartbeat blinks slowest
	assign led_heart = heart_cnt[boardcfg_pkg::heart_width-1 -: boardcfg_pkg::led_width];
	assign led_test = reg_test;
	assign led_test1 = reg_test1;

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_boardcfg \
	-f tb.f -o sim_boardcfg || { echo "build failed"; exit 1; }
# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/sim_boardcfg +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && echo "result: pass" \
	|| { echo "result: fail"; exit 1; }

//--- tb.f
logic/boardcfg_pkg.sv
logic/freq_counter_bank.sv
logic/cfg_register_file.sv
logic/status_readout.sv
logic/boardcfg_top.sv
verification/boardcfg_checker.sv
verification/tb_boardcfg.sv

//--- verification/boardcfg_checker.sv
`timescale 1ns/1ps

module boardcfg_checker (
	input logic hw,
	input logic rst,
	input logic wr_stb,
	input logic [boardcfg_pkg::addr_width-1:0] wr_addr,
	input logic [boardcfg_pkg::reg_width-1:0] wr_data,
	input logic [boardcfg_pkg::addr_width-1:0] rd_addr,
	input logic [boardcfg_pkg::reg_width-1:0] rd_data,
	input logic dsp_start,
	input logic dsp_reset,
	input logic cfg_reset,
	input logic [boardcfg_pkg::n_fcnt*boardcfg_pkg::cnt_width-1:0] freq_counts
);

	boardcfg_pkg::cfg_word_u wr_word;
	logic start_write;
	logic soft_write;
	logic unmapped;
	// cycles since rst fell and since the last soft reset, both saturating
	int since_rst;
	int soft_age;
	// own copy of the gate position
	logic [boardcfg_pkg::gate_width-1:0] phase;
	int fail_count = 0;

	assign wr_word = wr_data;
	assign start_write = wr_stb && (wr_addr == boardcfg_pkg::addr_cmd)
		&& wr_word.cmd_view.stb_start;
	assign soft_write = wr_stb && (wr_addr == boardcfg_pkg::addr_cmd)
		&& wr_word.cmd_view.stb_dspreset;
	// gap below the frequency slots and everything above them
	assign unmapped = (rd_addr > boardcfg_pkg::addr_status && rd_addr < boardcfg_pkg::addr_freq_base)
		|| (rd_addr >= 6'(boardcfg_pkg::addr_freq_base + boardcfg_pkg::n_fcnt));

	always_ff @(posedge hw) begin
		if (rst) begin
			since_rst <= 0;
			soft_age <= boardcfg_pkg::reset_stretch;
			phase <= '0;
		end else begin
			if (since_rst < boardcfg_pkg::reset_stretch) begin
				since_rst <= since_rst + 1;
			end
			if (soft_write) begin
				soft_age <= 0;
			end else if (soft_age < boardcfg_pkg::reset_stretch) begin
				soft_age <= soft_age + 1;
			end
			phase <= phase + 1'b1;
		end
	end

	cfg_reset_stretch: assert property (@(posedge hw) disable iff (rst)
		cfg_reset == (since_rst < boardcfg_pkg::reset_stretch))
	else begin
		fail_count++;
		$error("cfg_reset does not last the stretch after rst");
	end

	// dsp reset covers cfg_reset and each soft reset
	dsp_reset_stretch: assert property (@(posedge hw) disable iff (rst)
		dsp_reset == (cfg_reset || soft_age < boardcfg_pkg::reset_stretch))
	else begin
		fail_count++;
		$error("dsp_reset does not follow cfg_reset and the soft reset");
	end

	start_follows_write: assert property (@(posedge hw) disable iff (rst)
		dsp_start == $past(start_write))
	else begin
		fail_count++;
		$error("dsp_start not on the cycle after a start write");
	end

	start_one_cycle: assert property (@(posedge hw) disable iff (rst)
		dsp_start |=> !dsp_start)
	else begin
		fail_count++;
		$error("dsp_start wider than one cycle");
	end

	// new counts only show up right after a window closes
	counts_on_boundary: assert property (@(posedge hw) disable iff (rst)
		!$stable(freq_counts) |-> (phase == '0))
	else begin
		fail_count++;
		$error("freq_counts changed inside a window");
	end

	revision_read: assert property (@(posedge hw) disable iff (rst)
		(rd_addr == boardcfg_pkg::addr_rev) |=> (rd_data == boardcfg_pkg::revision_word))
	else begin
		fail_count++;
		$error("revision read returned the wrong word");
	end

	unmapped_read: assert property (@(posedge hw) disable iff (rst)
		unmapped |=> (rd_data == '0))
	else begin
		fail_count++;
		$error("unmapped address read nonzero");
	end

endmodule

//--- verification/tb_boardcfg.sv
`timescale 1ns/1ps

module tb_boardcfg;

	localparam int n = boardcfg_pkg::n_fcnt;
	localparam int window = boardcfg_pkg::window_cycles;
	// six windows plus margin, covers both measurement rounds
	localparam int cycle_limit = 6 * window + 400;
	// extra wait after a period change, past the synchronizer delay
	localparam int settle = 8;
	localparam int reset_cycles = 3;

	logic hw = 1'b0;
	logic rst;
	logic [n-1:0] fin = '0;
	logic wr_stb;
	logic [boardcfg_pkg::addr_width-1:0] wr_addr;
	logic [boardcfg_pkg::reg_width-1:0] wr_data;
	logic [boardcfg_pkg::addr_width-1:0] rd_addr;
	logic [boardcfg_pkg::reg_width-1:0] rd_data;
	logic [boardcfg_pkg::led_width-1:0] led_heart;
	logic [boardcfg_pkg::led_width-1:0] led_test;
	logic [boardcfg_pkg::led_width-1:0] led_test1;
	logic dsp_start;
	logic dsp_reset;
	logic dsp_resetacc;
	logic [boardcfg_pkg::nshot_width-1:0] dsp_nshot;
	logic [boardcfg_pkg::reg_width-1:0] dsp_decimator;
	logic cfg_reset;

	logic [31:0] seed;
	int errors;
	int cycles = 0;
	// period of each board clock in hw cycles, and its position in it
	int period [n];
	int phase [n];

	boardcfg_top uut (
		.hw            (hw),
		.rst           (rst),
		.fin           (fin),
		.wr_stb        (wr_stb),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.led_heart     (led_heart),
		.led_test      (led_test),
		.led_test1     (led_test1),
		.dsp_start     (dsp_start),
		.dsp_reset     (dsp_reset),
		.dsp_resetacc  (dsp_resetacc),
		.dsp_nshot     (dsp_nshot),
		.dsp_decimator (dsp_decimator),
		.cfg_reset     (cfg_reset)
	);

	// assertions ride along inside the DUT
	bind boardcfg_top boardcfg_checker chk (
		.hw          (hw),
		.rst         (rst),
		.wr_stb      (wr_stb),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.dsp_start   (dsp_start),
		.dsp_reset   (dsp_reset),
		.cfg_reset   (cfg_reset),
		.freq_counts (freq_counts)
	);

	always #10 hw = ~hw;

	// board clocks aligned to hw, high for the first half of each period
	always @(posedge hw) begin
		for (int i = 0; i < n; i++) begin
			if (phase[i] >= period[i] - 1) begin
				phase[i] <= 0;
			end else begin
				phase[i] <= phase[i] + 1;
			end
			fin[i] <= (phase[i] < period[i] / 2);
		end
	end

	always @(posedge hw) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_random(output logic [31:0] v);
		seed = lcg_step(seed);
		v = seed;
	endtask

	task automatic pick_periods();
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			draw_random(r);
			// upper bits, low LCG bits repeat quickly
			period[i] = 2 + int'(r[27:24]);
		end
	endtask

	task automatic write_reg(input logic [5:0] a, input logic [31:0] d);
		@(posedge hw);
		wr_stb <= 1'b1;
		wr_addr <= a;
		wr_data <= d;
		@(posedge hw);
		wr_stb <= 1'b0;
	endtask

	// one cycle latency, sampled mid-cycle
	task automatic read_reg(input logic [5:0] a, output logic [31:0] d);
		@(posedge hw);
		rd_addr <= a;
		@(posedge hw);
		@(negedge hw);
		d = rd_data;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// edge count over one window, either rounding allowed
	task automatic check_count(input string name, input int p, input logic [31:0] act);
		int lo;
		int hi;
		lo = window / p;
		hi = (window + p - 1) / p;
		assert (act == lo || act == hi) else begin
			errors++;
			$display("FAIL %s: expected %0d or %0d, actual %0d", name, lo, hi, act);
		end
	endtask

	task automatic check_slots(input string name);
		logic [31:0] d;
		for (int i = 0; i < n; i++) begin
			read_reg(boardcfg_pkg::addr_freq_base + 6'(i), d);
			check_count($sformatf("%s slot %0d", name, i), period[i], d);
		end
	endtask

	// heartbeat byte is the top of a counter that starts when rst falls
	// called mid-cycle, so cycles holds the count of edges so far
	task automatic check_heartbeat(input string name);
		logic [31:0] beats;
		logic [31:0] exp;
		beats = 32'(cycles - reset_cycles);
		exp = (beats >> (boardcfg_pkg::heart_width - boardcfg_pkg::led_width)) & 32'h0000_00ff;
		check_value(name, exp, led_heart);
	endtask

	initial begin
		logic [31:0] v;
		logic [31:0] d;
		logic [15:0] nshot;
		rst = 1'b1;
		wr_stb = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rd_addr = '0;
		seed = 32'h2a90_fee0;
		errors = 0;
		pick_periods();
		repeat (reset_cycles) @(posedge hw);
		rst <= 1'b0;

		// state right out of reset
		@(negedge hw);
		check_value("reset dsp_start", 0, dsp_start);
		check_value("reset dsp_resetacc", 0, dsp_resetacc);
		check_value("reset rd_data", 0, rd_data);
		check_value("reset dsp_reset", 1, dsp_reset);
		check_value("reset cfg_reset", 1, cfg_reset);
		check_heartbeat("reset led_heart");
		read_reg(boardcfg_pkg::addr_status, d);
		check_value("reset status", 0, d);

		// random LED and decimator values
		for (int k = 0; k < 4; k++) begin
			draw_random(v);
			write_reg(boardcfg_pkg::addr_led, v);
			read_reg(boardcfg_pkg::addr_led, d);
			check_value("led readback", {16'h0000, v[15:0]}, d);
			check_value("led_test", v[7:0], led_test);
			check_value("led_test1", v[15:8], led_test1);
			draw_random(v);
			write_reg(boardcfg_pkg::addr_decim, v);
			read_reg(boardcfg_pkg::addr_decim, d);
			check_value("decimator readback", v, d);
			check_value("dsp_decimator", v, dsp_decimator);
		end
		read_reg(boardcfg_pkg::addr_rev, d);
		check_value("revision", boardcfg_pkg::revision_word, d);
		read_reg(6'h08, d);
		check_value("unmapped 0x08", 0, d);
		read_reg(6'h30, d);
		check_value("unmapped 0x30", 0, d);

		// start strobe with resetacc set
		draw_random(v);
		nshot = v[31:16];
		write_reg(boardcfg_pkg::addr_cmd, {nshot, 13'h0000, 3'b101});
		@(negedge hw);
		check_value("dsp_nshot", nshot, dsp_nshot);
		check_value("dsp_resetacc set", 1, dsp_resetacc);
		// soft DSP reset alone
		write_reg(boardcfg_pkg::addr_cmd, {nshot, 13'h0000, 3'b010});
		@(negedge hw);
		check_value("dsp_reset after soft reset", 1, dsp_reset);
		check_value("cfg_reset after soft reset", 0, cfg_reset);
		check_value("dsp_resetacc clear", 0, dsp_resetacc);
		read_reg(boardcfg_pkg::addr_cmd, d);
		check_value("cmd readback", {nshot, 16'h0000}, d);

		// frequency slots after two windows
		repeat (2 * window + settle) @(posedge hw);
		check_slots("first periods");
		read_reg(boardcfg_pkg::addr_status, d);
		check_value("status after windows", {nshot, 15'h0000, 1'b1}, d);

		// new periods, mid-window on purpose
		@(negedge hw);
		pick_periods();
		repeat (2 * window + settle) @(posedge hw);
		check_slots("second periods");
		check_heartbeat("led_heart");

		$display("error count: %0d testbench, %0d checker", errors, uut.chk.fail_count);
		if (errors == 0 && uut.chk.fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
